// File: Makefile
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard src/*.sv testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
src/core_cfg_pkg.sv
src/rv_isa_pkg.sv
src/fetch_if.sv
src/issue_if.sv
src/frontend.sv
src/id_stage.sv
src/regfile.sv
src/ex_stage.sv
src/rv_core.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv

// File: src/core_cfg_pkg.sv
/*
 * Core configuration package
 * Data and address width, word types for data, addresses,
 * instructions and register indices, and the default reset PC
 */

`default_nettype none

package core_cfg_pkg;

  // Machine word width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;

  // Reset PC when the top level does not override it
  localparam addr_t DefaultBootAddr = '0;

endpackage

`default_nettype wire

// File: src/ex_stage.sv
/*
 * Execute stage
 * ALU, branch and jump resolution with PC redirect,
 * register write-back and the registered commit port
 */

`default_nettype none

module ex_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  issue_if.execute               issue_i,
  output logic                   redirect_o,
  output core_cfg_pkg::addr_t    target_o,
  output logic                   wb_we_o,
  output core_cfg_pkg::reg_idx_t wb_rd_o,
  output core_cfg_pkg::xlen_t    wb_data_o,
  output logic                   commit_valid_o,
  output core_cfg_pkg::addr_t    commit_pc_o,
  output core_cfg_pkg::reg_idx_t commit_rd_o,
  output core_cfg_pkg::xlen_t    commit_wdata_o,
  output logic                   commit_illegal_o
);
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  xlen_t result;
  logic  taken;
  logic  no_result;

  // --------------------------------------
  // ALU and branch compare
  // --------------------------------------
  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (issue_i.alu_op)
      ALU_ADD:    result = issue_i.op_a + issue_i.op_b;
      ALU_SUB:    result = issue_i.op_a - issue_i.op_b;
      ALU_AND:    result = issue_i.op_a & issue_i.op_b;
      ALU_OR:     result = issue_i.op_a | issue_i.op_b;
      ALU_XOR:    result = issue_i.op_a ^ issue_i.op_b;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(issue_i.op_a) < $signed(issue_i.op_b)};
      ALU_PASS_B: result = issue_i.op_b;
      ALU_BEQ:    taken = (issue_i.op_a == issue_i.op_b);
      ALU_BNE:    taken = (issue_i.op_a != issue_i.op_b);
      ALU_JAL: begin
        // Link address
        result = issue_i.pc + addr_t'(4);
        taken  = 1'b1;
      end
      default: result = '0;
    endcase
  end

  // Branches and illegal ops report neither rd nor data
  assign no_result = issue_i.illegal | (issue_i.alu_op == ALU_BEQ) |
                     (issue_i.alu_op == ALU_BNE);

  assign redirect_o = issue_i.valid & ~issue_i.illegal & taken;
  assign target_o   = issue_i.pc + issue_i.imm;

  assign wb_we_o   = issue_i.valid & issue_i.we;
  assign wb_rd_o   = issue_i.rd;
  assign wb_data_o = result;

  // --------------------------------------
  // Commit port
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= issue_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i.valid) begin
      commit_pc_o      <= issue_i.pc;
      commit_illegal_o <= issue_i.illegal;
      commit_rd_o      <= no_result ? '0 : issue_i.rd;
      commit_wdata_o   <= no_result ? '0 : result;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_if.sv
/*
 * Fetch bus from the frontend to the ID stage
 * Valid/ready handshake carrying one instruction and its PC
 */

`default_nettype none

interface fetch_if;
  import core_cfg_pkg::*;

  logic   valid;
  logic   ready;
  instr_t instr;
  addr_t  pc;

  modport frontend (output valid, output instr, output pc, input ready);
  modport decode (input valid, input instr, input pc, output ready);

endinterface

`default_nettype wire

// File: src/frontend.sv
/*
 * Instruction frontend
 * PC generation, APB read master for instruction fetch and a
 * one-entry fetch buffer towards the ID stage
 */

`default_nettype none

module frontend #(
  parameter core_cfg_pkg::addr_t BootAddr = core_cfg_pkg::DefaultBootAddr
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  output logic                 psel_o,
  output logic                 penable_o,
  output core_cfg_pkg::addr_t  paddr_o,
  input  core_cfg_pkg::instr_t prdata_i,
  input  logic                 pready_i,
  input  logic                 redirect_i,
  input  core_cfg_pkg::addr_t  target_i,
  fetch_if.frontend            fetch_o
);
  import core_cfg_pkg::*;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q, state_d;
  addr_t      pc_q;
  addr_t      fetch_addr_q;
  addr_t      next_addr;
  logic       discard_q;
  logic       buf_valid_q;
  instr_t     buf_instr_q;
  addr_t      buf_pc_q;
  logic       take;
  logic       buf_free;
  logic       done;
  logic       drop;
  logic       start;

  assign take     = buf_valid_q & fetch_o.ready;
  assign buf_free = ~buf_valid_q | take;
  assign done     = (state_q == APB_ACCESS) & pready_i;
  // Data of this transfer belongs to a squashed path
  assign drop     = discard_q | redirect_i;
  // The buffer is always empty while a transfer runs
  assign start    = ((state_q == APB_IDLE) & (buf_free | redirect_i)) | (done & drop);
  assign next_addr = redirect_i ? target_i : pc_q;

  // --------------------------------------
  // APB transfer FSM
  // --------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   if (start) state_d = APB_SETUP;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: if (done) state_d = drop ? APB_SETUP : APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= APB_IDLE;
      pc_q         <= BootAddr;
      fetch_addr_q <= BootAddr;
      discard_q    <= 1'b0;
      buf_valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        fetch_addr_q <= next_addr;
        pc_q         <= next_addr + addr_t'(4);
        discard_q    <= 1'b0;
      end else if (redirect_i) begin
        // Transfer still running, finish it and throw the data away
        pc_q      <= target_i;
        discard_q <= 1'b1;
      end
      if (redirect_i) begin
        buf_valid_q <= 1'b0;
      end else if (done & ~drop) begin
        buf_valid_q <= 1'b1;
      end else if (take) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // --------------------------------------
  // Fetch buffer
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (done & ~drop) begin
      buf_instr_q <= prdata_i;
      buf_pc_q    <= fetch_addr_q;
    end
  end

  assign psel_o    = (state_q != APB_IDLE);
  assign penable_o = (state_q == APB_ACCESS);
  assign paddr_o   = fetch_addr_q;

  assign fetch_o.valid = buf_valid_q;
  assign fetch_o.instr = buf_instr_q;
  assign fetch_o.pc    = buf_pc_q;

endmodule

`default_nettype wire

// File: src/id_stage.sv
/*
 * Instruction decode stage
 * RV32I subset decoder, immediate generation, operand selection
 * and the issue register feeding the EX stage
 */

`default_nettype none

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_i,
  output core_cfg_pkg::reg_idx_t rs1_o,
  output core_cfg_pkg::reg_idx_t rs2_o,
  input  core_cfg_pkg::xlen_t    rs1_data_i,
  input  core_cfg_pkg::xlen_t    rs2_data_i,
  fetch_if.decode                fetch_i,
  issue_if.issue                 issue_o
);
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  instr_t     instr;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_u, imm_b, imm_j;
  alu_op_e    dec_alu_op;
  xlen_t      dec_op_b;
  xlen_t      dec_imm;
  logic       dec_we;
  logic       dec_illegal;
  logic       fetch_take;

  assign instr  = fetch_i.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------
  // Decoder
  // --------------------------------------
  always_comb begin
    dec_alu_op  = ALU_ADD;
    dec_op_b    = rs2_data_i;
    dec_imm     = imm_i;
    dec_we      = 1'b1;
    dec_illegal = 1'b0;
    case (instr[6:0])
      OPC_OP: begin
        if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) dec_alu_op = ALU_SUB;
        else if (funct7 != F7_BASE) dec_illegal = 1'b1;
        else if (funct3 == F3_ADD_SUB) dec_alu_op = ALU_ADD;
        else if (funct3 == F3_SLT) dec_alu_op = ALU_SLT;
        else if (funct3 == F3_XOR) dec_alu_op = ALU_XOR;
        else if (funct3 == F3_OR) dec_alu_op = ALU_OR;
        else if (funct3 == F3_AND) dec_alu_op = ALU_AND;
        else dec_illegal = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_op_b = imm_i;
        case (funct3)
          F3_ADD_SUB: dec_alu_op = ALU_ADD;
          F3_XOR:     dec_alu_op = ALU_XOR;
          F3_OR:      dec_alu_op = ALU_OR;
          F3_AND:     dec_alu_op = ALU_AND;
          default:    dec_illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        dec_op_b   = imm_u;
        dec_alu_op = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        dec_imm = imm_b;
        dec_we  = 1'b0;
        if (funct3 == F3_BEQ) dec_alu_op = ALU_BEQ;
        else if (funct3 == F3_BNE) dec_alu_op = ALU_BNE;
        else dec_illegal = 1'b1;
      end
      OPC_JAL: begin
        dec_imm    = imm_j;
        dec_alu_op = ALU_JAL;
      end
      default: dec_illegal = 1'b1;
    endcase
    if (dec_illegal) begin
      dec_we     = 1'b0;
      dec_alu_op = ALU_ADD;
    end
  end

  // EX consumes the issue register every cycle
  assign fetch_i.ready = 1'b1;
  assign fetch_take    = fetch_i.valid & fetch_i.ready;

  // --------------------------------------
  // Issue register
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_o.valid <= 1'b0;
    end else begin
      issue_o.valid <= fetch_take & ~redirect_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_take) begin
      issue_o.alu_op  <= dec_alu_op;
      issue_o.op_a    <= rs1_data_i;
      issue_o.op_b    <= dec_op_b;
      issue_o.imm     <= dec_imm;
      issue_o.rd      <= instr[11:7];
      issue_o.pc      <= fetch_i.pc;
      // Writes to x0 are dropped here
      issue_o.we      <= dec_we & (instr[11:7] != '0);
      issue_o.illegal <= dec_illegal;
    end
  end

endmodule

`default_nettype wire

// File: src/issue_if.sv
/*
 * Issue bus from the ID stage to the EX stage
 * One decoded op per cycle, no back-pressure
 */

`default_nettype none

interface issue_if;
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  logic     valid;
  alu_op_e  alu_op;
  xlen_t    op_a;
  xlen_t    op_b;
  xlen_t    imm;
  reg_idx_t rd;
  addr_t    pc;
  logic     we;
  logic     illegal;

  modport issue (output valid, alu_op, op_a, op_b, imm, rd, pc, we, illegal);
  modport execute (input valid, alu_op, op_a, op_b, imm, rd, pc, we, illegal);

endinterface

`default_nettype wire

// File: src/regfile.sv
/*
 * Integer register file
 * x1..x31 with two read ports, one write port and
 * same-cycle write-to-read bypass; x0 reads as zero
 */

`default_nettype none

module regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  core_cfg_pkg::reg_idx_t rs1_i,
  input  core_cfg_pkg::reg_idx_t rs2_i,
  output core_cfg_pkg::xlen_t    rs1_data_o,
  output core_cfg_pkg::xlen_t    rs2_data_o,
  input  logic                   we_i,
  input  core_cfg_pkg::reg_idx_t rd_i,
  input  core_cfg_pkg::xlen_t    wdata_i
);
  import core_cfg_pkg::*;

  xlen_t regs_q [1:31];

  function automatic xlen_t read_port(reg_idx_t idx);
    xlen_t val;
    if (idx == '0) begin
      val = '0;
    end else if (we_i && idx == rd_i) begin
      // Result written this cycle by EX
      val = wdata_i;
    end else begin
      val = regs_q[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_core.sv
/*
 * RV32I subset core, top level
 * Frontend, ID stage, register file and EX stage with an APB
 * instruction fetch port and a single commit port
 */

`default_nettype none

module rv_core #(
  parameter core_cfg_pkg::addr_t BootAddr = core_cfg_pkg::DefaultBootAddr
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // APB fetch master
  output logic                   psel_o,
  output logic                   penable_o,
  output core_cfg_pkg::addr_t    paddr_o,
  input  core_cfg_pkg::instr_t   prdata_i,
  input  logic                   pready_i,
  // Retired instructions
  output logic                   commit_valid_o,
  output core_cfg_pkg::addr_t    commit_pc_o,
  output core_cfg_pkg::reg_idx_t commit_rd_o,
  output core_cfg_pkg::xlen_t    commit_wdata_o,
  output logic                   commit_illegal_o
);
  import core_cfg_pkg::*;

  logic     redirect;
  addr_t    target;
  reg_idx_t rs1_idx, rs2_idx;
  xlen_t    rs1_data, rs2_data;
  logic     wb_we;
  reg_idx_t wb_rd;
  xlen_t    wb_data;

  fetch_if fetch_bus ();
  issue_if issue_bus ();

  frontend #(
    .BootAddr ( BootAddr )
  ) i_frontend (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .psel_o     ( psel_o    ),
    .penable_o  ( penable_o ),
    .paddr_o    ( paddr_o   ),
    .prdata_i   ( prdata_i  ),
    .pready_i   ( pready_i  ),
    .redirect_i ( redirect  ),
    .target_i   ( target    ),
    .fetch_o    ( fetch_bus )
  );

  id_stage i_id_stage (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .redirect_i ( redirect  ),
    .rs1_o      ( rs1_idx   ),
    .rs2_o      ( rs2_idx   ),
    .rs1_data_i ( rs1_data  ),
    .rs2_data_i ( rs2_data  ),
    .fetch_i    ( fetch_bus ),
    .issue_o    ( issue_bus )
  );

  regfile i_regfile (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .rs1_i      ( rs1_idx  ),
    .rs2_i      ( rs2_idx  ),
    .rs1_data_o ( rs1_data ),
    .rs2_data_o ( rs2_data ),
    .we_i       ( wb_we    ),
    .rd_i       ( wb_rd    ),
    .wdata_i    ( wb_data  )
  );

  ex_stage i_ex_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .issue_i          ( issue_bus        ),
    .redirect_o       ( redirect         ),
    .target_o         ( target           ),
    .wb_we_o          ( wb_we            ),
    .wb_rd_o          ( wb_rd            ),
    .wb_data_o        ( wb_data          ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

`default_nettype wire

// File: src/rv_isa_pkg.sv
/*
 * RV32I subset encodings
 * Major opcodes, funct3 and funct7 values of the supported
 * instructions, and the ALU operation enum used by ID and EX
 */

`default_nettype none

package rv_isa_pkg;

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU and branch functions
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 of register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B,
    ALU_BEQ,
    ALU_BNE,
    ALU_JAL
  } alu_op_e;

endpackage

`default_nettype wire

// File: testbench/core_stimulus.mem
// Program words from address 0, one per line
// @40 record count, from @41 records: pc rd wdata illegal
@00
00500093 // 00 addi x1, x0, 5
ffd08113 // 04 addi x2, x1, -3
002081b3 // 08 add  x3, x1, x2
40310233 // 0c sub  x4, x2, x3
001222b3 // 10 slt  x5, x4, x1
00324333 // 14 xor  x6, x4, x3
001363b3 // 18 or   x7, x6, x1
0033f433 // 1c and  x8, x7, x3
123454b7 // 20 lui  x9, 0x12345
6784e493 // 24 ori  x9, x9, 0x678
fff4c513 // 28 xori x10, x9, -1
0f057593 // 2c andi x11, x10, 0xf0
001090b3 // 30 sll  x1, x1, x1 (illegal here)
00008613 // 34 addi x12, x1, 0
00209463 // 38 bne  x1, x2, +8 (taken)
00100693 // 3c addi x13, x0, 1 (squashed)
00208463 // 40 beq  x1, x2, +8 (not taken)
00140463 // 44 beq  x8, x1, +8 (taken)
00100713 // 48 addi x14, x0, 1 (squashed)
008007ef // 4c jal  x15, +8
00100813 // 50 addi x16, x0, 1 (squashed)
00c78833 // 54 add  x16, x15, x12
0000006f // 58 jal  x0, 0
@40
00000015
00000000 00000001 00000005 00000000
00000004 00000002 00000002 00000000
00000008 00000003 00000007 00000000
0000000c 00000004 fffffffb 00000000
00000010 00000005 00000001 00000000
00000014 00000006 fffffffc 00000000
00000018 00000007 fffffffd 00000000
0000001c 00000008 00000005 00000000
00000020 00000009 12345000 00000000
00000024 00000009 12345678 00000000
00000028 0000000a edcba987 00000000
0000002c 0000000b 00000080 00000000
00000030 00000000 00000000 00000001
00000034 0000000c 00000005 00000000
00000038 00000000 00000000 00000000
00000040 00000000 00000000 00000000
00000044 00000000 00000000 00000000
0000004c 0000000f 00000050 00000000
00000054 00000010 00000055 00000000
00000058 00000000 0000005c 00000000
00000058 00000000 0000005c 00000000

// File: testbench/rv_core_properties.sv
/*
 * Concurrent checks on the APB fetch port and the commit port
 * of rv_core, attached to the core with bind
 */

`default_nettype none

module rv_core_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                psel_o,
  input logic                penable_o,
  input core_cfg_pkg::addr_t paddr_o,
  input logic                pready_i,
  input logic                commit_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Access phase entered only from a setup cycle
  penable_after_setup_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(penable_o) |-> $past(psel_o && !penable_o)
  ) else $error("penable_o rose without a preceding setup cycle");

  // Wait states keep the transfer unchanged
  apb_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_o && penable_o && !pready_i) |=> (psel_o && penable_o && $stable(paddr_o))
  ) else $error("APB transfer changed while pready_i was low");

  paddr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_o |-> (paddr_o[1:0] == 2'b00)
  ) else $error("paddr_o is not word aligned");

  commit_quiet_in_reset_a : assert property (@(posedge clk_i)
    !rst_ni |-> !commit_valid_o
  ) else $error("commit_valid_o high during reset");

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
/*
 * Testbench for rv_core
 * Clock and reset, APB instruction memory with random wait states,
 * commit checker against the records of the stimulus file, watchdog
 */

`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  import core_cfg_pkg::*;

  localparam addr_t       BootAddr     = DefaultBootAddr;
  localparam int unsigned StimWords    = 256;
  localparam logic [7:0]  CountIdx     = 8'h40;
  localparam logic [7:0]  RecBase      = 8'h41;
  localparam int unsigned CyclesPerRec = 40;

  logic     clk     = 1'b0;
  logic     rst_n;
  logic     psel;
  logic     penable;
  addr_t    paddr;
  instr_t   prdata  = '0;
  logic     pready  = 1'b0;
  logic     commit_valid;
  addr_t    commit_pc;
  reg_idx_t commit_rd;
  xlen_t    commit_wdata;
  logic     commit_illegal;

  // Program image at word 0, record count and records above it
  logic [31:0] stim_mem [0:StimWords-1];
  int          rec_count;

  logic [31:0] lfsr_state = 32'ha0ca_cb2e;
  logic [1:0]  wait_cnt   = 2'd0;
  logic        wait_hi;
  logic        wait_lo;

  always #10 clk = ~clk;

  rv_core #(
    .BootAddr ( BootAddr )
  ) UUT (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .psel_o           ( psel           ),
    .penable_o        ( penable        ),
    .paddr_o          ( paddr          ),
    .prdata_i         ( prdata         ),
    .pready_i         ( pready         ),
    .commit_valid_o   ( commit_valid   ),
    .commit_pc_o      ( commit_pc      ),
    .commit_rd_o      ( commit_rd      ),
    .commit_wdata_o   ( commit_wdata   ),
    .commit_illegal_o ( commit_illegal )
  );

  bind rv_core rv_core_properties i_properties (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .psel_o         ( psel_o         ),
    .penable_o      ( penable_o      ),
    .paddr_o        ( paddr_o        ),
    .pready_i       ( pready_i       ),
    .commit_valid_o ( commit_valid_o )
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_next_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
  endfunction

  function automatic instr_t fetch_word(addr_t addr);
    return stim_mem[{2'b00, addr[7:2]}];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic wait_commit();
    do begin
      @(negedge clk);
    end while (!commit_valid);
  endtask

  // --------------------------------------
  // APB slave, 0 to 3 wait states
  // --------------------------------------
  always @(posedge clk) begin
    #1;
    if (psel && !penable) begin
      wait_hi  = lfsr_next_bit();
      wait_lo  = lfsr_next_bit();
      wait_cnt = {wait_hi, wait_lo};
      pready   = 1'b0;
    end else if (psel && penable && wait_cnt == 2'd0) begin
      pready = 1'b1;
      prdata = fetch_word(paddr);
    end else if (psel && penable) begin
      wait_cnt = wait_cnt - 2'd1;
      pready   = 1'b0;
    end else begin
      pready = 1'b0;
    end
  end

  // --------------------------------------
  // Main sequence and commit checker
  // --------------------------------------
  initial begin
    logic [7:0] rec;
    string      tag;
    rst_n = 1'b0;
    for (int i = 0; i < StimWords; i++) begin
      stim_mem[i[7:0]] = 32'hbad0_0000 ^ i;
    end
    $readmemh("testbench/core_stimulus.mem", stim_mem);
    rec_count = int'(stim_mem[CountIdx]);
    if (rec_count < 1 || rec_count > int'((StimWords - RecBase) / 4)) begin
      $display("The stimulus file holds no valid record count");
      $display("CHECKS FAILED");
      $fatal(1, "Bad record count");
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("reset psel", 32'd0, {31'b0, psel});
    check_value("reset commit_valid", 32'd0, {31'b0, commit_valid});
    @(posedge clk);
    #1 rst_n = 1'b1;

    // Nothing retires before the first fetch
    do begin
      @(negedge clk);
      check_value("early commit_valid", 32'd0, {31'b0, commit_valid});
    end while (!psel);
    check_value("boot fetch paddr", BootAddr, paddr);
    check_value("boot fetch penable", 32'd0, {31'b0, penable});

    for (int n = 0; n < rec_count; n++) begin
      wait_commit();
      rec = RecBase + 8'(4 * n);
      tag = $sformatf("commit %0d", n);
      check_value({tag, " pc"}, stim_mem[rec], commit_pc);
      check_value({tag, " rd"}, stim_mem[rec + 8'd1], {27'b0, commit_rd});
      check_value({tag, " wdata"}, stim_mem[rec + 8'd2], commit_wdata);
      check_value({tag, " illegal"}, stim_mem[rec + 8'd3], {31'b0, commit_illegal});
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog scaled by the number of expected commits
  initial begin
    wait (rec_count != 0);
    repeat (rec_count * CyclesPerRec) @(posedge clk);
    $display("Watchdog expired, the core stopped committing before all %0d records",
             rec_count);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire
